// ==== verilog.f ====
src/host_pkg.sv
src/io_port_arbiter.sv
src/host_regs.sv
src/mem_model.sv
src/host_top.sv
test/host_properties.sv
test/tb_host.sv

// ==== test/host_testdata.txt ====
# test port(0 loader, 1 proc, 2 loader paired with next proc line) op(0 rd, 1 wr)
# addr(hex) wdata(hex) expected read data(hex, zero for writes)
1 0 1 0010 11111111 00000000
1 0 1 0011 22222222 00000000
1 0 1 00ff cafef00d 00000000
1 0 0 0010 00000000 11111111
1 1 0 0011 00000000 22222222
1 1 0 7f10 00000000 11111111
1 0 0 01ff 00000000 cafef00d
1 0 1 4a11 33333333 00000000
1 1 0 0011 00000000 33333333
2 0 1 8000 000000a5 00000000
2 1 0 8000 00000000 000000a5
2 1 1 8000 ffffff3c 00000000
2 0 0 8000 00000000 0000003c
2 0 0 8008 00000000 00000000
2 1 1 8008 12345678 00000000
2 1 0 8008 00000000 00000000
2 0 0 8000 00000000 0000003c
3 0 0 8004 00000000 00000000
3 0 1 8006 00000001 00000000
3 1 0 8004 00000000 00000004
3 1 1 8004 00000000 00000000
3 0 1 8007 00000000 00000000
3 0 0 8005 00000000 0000000d
3 1 1 8005 00000000 00000000
3 0 0 8004 00000000 0000000f
3 1 1 8006 00000000 00000000
3 1 0 8004 00000000 0000000f
4 2 1 0020 aaaa0001 00000000
4 1 1 0021 bbbb0002 00000000
4 2 0 0021 00000000 bbbb0002
4 1 0 0020 00000000 aaaa0001
4 2 0 8000 00000000 0000003c
4 1 0 0021 00000000 bbbb0002
5 0 1 0040 01020304 00000000
5 1 1 0041 05060708 00000000
5 0 0 0041 00000000 05060708
5 1 0 0040 00000000 01020304
5 0 0 8004 00000000 0000000f
5 0 1 c000 00000081 00000000
5 1 0 8000 00000000 00000081

// ==== test/tb_host.sv ====
// Testbench for host_top, run from the project root.
// Vectors come from test/host_testdata.txt; port 2 issues the loader command
// together with the processor command on the following line.
// Response ready on both ports comes from a 16-bit LFSR for back-pressure.
`timescale 1ns/100ps
`default_nettype none

module tb_host;

  localparam int TIMEOUT = 200;

  logic                            clk_i;
  logic                            arst_n_i;
  host_pkg::io_cmd_t               load_cmd;
  logic                            load_cmd_v;
  logic                            load_cmd_ready;
  host_pkg::io_resp_t              load_resp;
  logic                            load_resp_v;
  logic                            load_resp_ready;
  host_pkg::io_cmd_t               proc_cmd;
  logic                            proc_cmd_v;
  logic                            proc_cmd_ready;
  host_pkg::io_resp_t              proc_resp;
  logic                            proc_resp_v;
  logic                            proc_resp_ready;
  logic [host_pkg::TRACE_W-1:0]    trace_en;
  logic [host_pkg::NUM_CORES-1:0]  finish;
  logic                            all_finished;

  int                              errors;
  int                              checks;
  int                              n_tests;
  int                              n_failed;
  logic                            timed_out;
  logic [15:0]                     lfsr_q;
  logic [host_pkg::TRACE_W-1:0]    exp_trace;
  logic [host_pkg::NUM_CORES-1:0]  exp_finish;

  int                              v_test[$];
  int                              v_port[$];
  logic                            v_op[$];
  logic [15:0]                     v_addr[$];
  logic [31:0]                     v_wdata[$];
  logic [31:0]                     v_exp[$];

  host_top u_dut
  (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .load_cmd_i        (load_cmd),
    .load_cmd_v_i      (load_cmd_v),
    .load_cmd_ready_o  (load_cmd_ready),
    .load_resp_o       (load_resp),
    .load_resp_v_o     (load_resp_v),
    .load_resp_ready_i (load_resp_ready),
    .proc_cmd_i        (proc_cmd),
    .proc_cmd_v_i      (proc_cmd_v),
    .proc_cmd_ready_o  (proc_cmd_ready),
    .proc_resp_o       (proc_resp),
    .proc_resp_v_o     (proc_resp_v),
    .proc_resp_ready_i (proc_resp_ready),
    .trace_en_o        (trace_en),
    .finish_o          (finish),
    .all_finished_o    (all_finished)
  );

  always #20 clk_i = ~clk_i;

  // Taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic drive_resp_ready();
    lfsr_q = lfsr_next(lfsr_q);
    load_resp_ready = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
    proc_resp_ready = lfsr_q[0];
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("FAILED %s: expected 0x%08h, got 0x%08h", name, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
  endtask

  function automatic logic resp_v_of(input int port);
    return (port == 0) ? load_resp_v : proc_resp_v;
  endfunction

  function automatic host_pkg::io_resp_t resp_of(input int port);
    return (port == 0) ? load_resp : proc_resp;
  endfunction

  function automatic host_pkg::io_cmd_t make_cmd(input int idx);
    host_pkg::io_cmd_t c;
    c.op   = host_pkg::io_op_e'(v_op[idx]);
    c.addr = host_pkg::io_addr_u'(v_addr[idx]);
    c.data = v_wdata[idx];
    return c;
  endfunction

  // Issue one command, then follow its response through back-pressure
  task automatic do_cmd(input int port, input host_pkg::io_cmd_t cmd, input logic [31:0] exp_data);
    string               pname;
    string               oname;
    int                  waited;
    int                  lat;
    int                  exp_lat;
    logic                rdy;
    logic                taken;
    host_pkg::io_resp_t  held;
    host_pkg::io_resp_t  cur;
    pname = (port == 0) ? "load" : "proc";
    oname = (port == 0) ? "proc" : "load";
    exp_lat = cmd.addr[15] ? 2 : 3;
    if (port == 0)
    begin
      load_cmd = cmd;
      load_cmd_v = 1'b1;
    end
    else
    begin
      proc_cmd = cmd;
      proc_cmd_v = 1'b1;
    end
    waited = 0;
    rdy = 1'b0;
    while (!rdy && !timed_out)
    begin
      drive_resp_ready();
      #1;
      rdy = (port == 0) ? load_cmd_ready : proc_cmd_ready;
      if (!rdy)
      begin
        @(negedge clk_i);
        waited++;
        if (waited >= TIMEOUT)
          report_timeout({pname, " command ready"});
      end
    end
    if (timed_out)
      return;
    @(negedge clk_i);
    if (port == 0)
      load_cmd_v = 1'b0;
    else
      proc_cmd_v = 1'b0;
    // Count cycles from the transfer edge to response valid
    lat = 0;
    while (!resp_v_of(port) && !timed_out)
    begin
      check_val({oname, "_resp_v_o"}, 0, resp_v_of(1 - port));
      drive_resp_ready();
      @(negedge clk_i);
      lat++;
      if (lat >= TIMEOUT)
        report_timeout({pname, " response valid"});
    end
    if (timed_out)
      return;
    check_val({pname, " response latency"}, exp_lat, lat);
    held = resp_of(port);
    taken = 1'b0;
    waited = 0;
    while (!taken && !timed_out)
    begin
      cur = resp_of(port);
      check_val({pname, "_resp_v_o"}, 1, resp_v_of(port));
      check_val({pname, "_resp_o.data"}, held.data, cur.data);
      check_val({oname, "_resp_v_o"}, 0, resp_v_of(1 - port));
      drive_resp_ready();
      taken = (port == 0) ? load_resp_ready : proc_resp_ready;
      @(negedge clk_i);
      waited++;
      if (!taken && waited >= TIMEOUT)
        report_timeout({pname, " response ready"});
    end
    if (timed_out)
      return;
    check_val({pname, "_resp_o.data"}, exp_data, held.data);
    check_val({pname, "_resp_o.op"}, cmd.op, held.op);
    check_val({pname, "_resp_v_o"}, 0, resp_v_of(port));
  endtask

  // Reference model of the host registers, from the register map
  task automatic check_host_outputs(input host_pkg::io_cmd_t cmd);
    logic [15:0] a;
    a = cmd.addr;
    if (cmd.op == host_pkg::IO_WRITE && a[15])
    begin
      if (a[5:2] == 4'd0)
        exp_trace = cmd.data[7:0];
      else if (a[5:2] == 4'd1)
        exp_finish[a[1:0]] = 1'b1;
    end
    check_val("trace_en_o", exp_trace, trace_en);
    check_val("finish_o", exp_finish, finish);
    check_val("all_finished_o", &exp_finish, all_finished);
  endtask

  task automatic read_vectors();
    int           fd;
    int           n;
    int           tn;
    int           pt;
    int           opv;
    logic [15:0]  av;
    logic [31:0]  dv;
    logic [31:0]  ev;
    string        line;
    fd = $fopen("test/host_testdata.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("Could not open test/host_testdata.txt from the working directory");
      return;
    end
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() < 2 || line.getc(0) == "#")
        continue;
      n = $sscanf(line, "%d %d %d %h %h %h", tn, pt, opv, av, dv, ev);
      if (n != 6)
      begin
        errors++;
        $display("Malformed vector line: %s", line);
      end
      else
      begin
        v_test.push_back(tn);
        v_port.push_back(pt);
        v_op.push_back(opv[0]);
        v_addr.push_back(av);
        v_wdata.push_back(dv);
        v_exp.push_back(ev);
      end
    end
    $fclose(fd);
  endtask

  task automatic end_test(input int tn, input int errs_before);
    n_tests++;
    if (errors == errs_before)
      $display("test %0d: ok", tn);
    else
    begin
      n_failed++;
      $display("test %0d: %0d errors", tn, errors - errs_before);
    end
  endtask

  initial
  begin
    int i;
    int cur_test;
    int test_errs;
    clk_i = 1'b0;
    arst_n_i = 1'b0;
    load_cmd = '0;
    load_cmd_v = 1'b0;
    load_resp_ready = 1'b0;
    proc_cmd = '0;
    proc_cmd_v = 1'b0;
    proc_resp_ready = 1'b0;
    errors = 0;
    checks = 0;
    n_tests = 0;
    n_failed = 0;
    timed_out = 1'b0;
    lfsr_q = 16'd41;
    exp_trace = '0;
    exp_finish = '0;
    repeat (8) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    // Test 0 covers the state right after reset
    test_errs = errors;
    check_val("load_cmd_ready_o", 1, load_cmd_ready);
    check_val("proc_cmd_ready_o", 1, proc_cmd_ready);
    check_val("load_resp_v_o", 0, load_resp_v);
    check_val("proc_resp_v_o", 0, proc_resp_v);
    check_val("trace_en_o", 0, trace_en);
    check_val("finish_o", 0, finish);
    check_val("all_finished_o", 0, all_finished);
    end_test(0, test_errs);
    read_vectors();
    if (v_test.size() == 0)
    begin
      errors++;
      $display("No test vectors were loaded");
    end
    i = 0;
    cur_test = -1;
    while (i < v_test.size() && !timed_out)
    begin
      if (v_test[i] != cur_test)
      begin
        if (cur_test >= 0)
          end_test(cur_test, test_errs);
        cur_test = v_test[i];
        test_errs = errors;
      end
      if (v_port[i] == 2 && i + 1 < v_test.size())
      begin
        // Both ports valid in the same cycle
        proc_cmd = make_cmd(i + 1);
        proc_cmd_v = 1'b1;
        do_cmd(0, make_cmd(i), v_exp[i]);
        if (!timed_out)
        begin
          check_host_outputs(make_cmd(i));
          do_cmd(1, make_cmd(i + 1), v_exp[i + 1]);
        end
        if (!timed_out)
          check_host_outputs(make_cmd(i + 1));
        i += 2;
      end
      else
      begin
        do_cmd((v_port[i] == 1) ? 1 : 0, make_cmd(i), v_exp[i]);
        if (!timed_out)
          check_host_outputs(make_cmd(i));
        i++;
      end
    end
    if (cur_test >= 0)
      end_test(cur_test, test_errs);
    $display("%0d tests, %0d failed, %0d checks, %0d errors", n_tests, n_failed, checks, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/host_properties.sv ====
// Handshake checks on the port arbiter, attached with bind.
// The command in flight is tracked here from the port handshakes alone.
`timescale 1ns/100ps
`default_nettype none

module host_properties
(
  input wire                  clk_i,
  input wire                  arst_n_i,
  input host_pkg::io_cmd_t    load_cmd_i,
  input wire                  load_cmd_v_i,
  input host_pkg::io_cmd_t    proc_cmd_i,
  input wire                  proc_cmd_v_i,
  input wire                  load_cmd_ready_o,
  input wire                  proc_cmd_ready_o,
  input wire                  reg_cmd_v_o,
  input wire                  mem_cmd_v_o,
  input host_pkg::io_resp_t   load_resp_o,
  input wire                  load_resp_v_o,
  input wire                  load_resp_ready_i,
  input host_pkg::io_resp_t   proc_resp_o,
  input wire                  proc_resp_v_o,
  input wire                  proc_resp_ready_i
);

  logic  cmd_xfer;
  logic  resp_xfer;
  logic  xfer_host;
  logic  in_flight_q;

  assign cmd_xfer  = (load_cmd_v_i && load_cmd_ready_o)
                   || (proc_cmd_v_i && proc_cmd_ready_o);
  assign resp_xfer = (load_resp_v_o && load_resp_ready_i)
                   || (proc_resp_v_o && proc_resp_ready_i);

  // Region of the command taken on the ports this cycle
  always_comb
  begin
    if (load_cmd_v_i && load_cmd_ready_o)
      xfer_host = load_cmd_i.addr[host_pkg::HOST_REGION_BIT];
    else
      xfer_host = proc_cmd_i.addr[host_pkg::HOST_REGION_BIT];
  end

  // Set by a command transfer, cleared by the response transfer
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      in_flight_q <= 1'b0;
    else if (cmd_xfer)
      in_flight_q <= 1'b1;
    else if (resp_xfer)
      in_flight_q <= 1'b0;
  end

  ready_low_when_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    in_flight_q |-> (!load_cmd_ready_o && !proc_cmd_ready_o))
    else $error("command ready high while a command is in flight");

  // Exactly the decoded target is strobed after a transfer
  one_target_strobe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd_xfer |=> ($past(xfer_host) ? (reg_cmd_v_o && !mem_cmd_v_o)
                                   : (mem_cmd_v_o && !reg_cmd_v_o)))
    else $error("wrong or both target strobes after a command transfer");

  no_stray_strobe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (reg_cmd_v_o || mem_cmd_v_o) |-> $past(cmd_xfer))
    else $error("target strobe without a command transfer");

  // Stalled responses keep valid and data
  load_resp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (load_resp_v_o && !load_resp_ready_i) |=> (load_resp_v_o && $stable(load_resp_o)))
    else $error("loader response dropped or changed before ready");

  proc_resp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (proc_resp_v_o && !proc_resp_ready_i) |=> (proc_resp_v_o && $stable(proc_resp_o)))
    else $error("processor response dropped or changed before ready");

endmodule

bind io_port_arbiter host_properties u_props
(
  .clk_i             (clk_i),
  .arst_n_i          (arst_n_i),
  .load_cmd_i        (load_cmd_i),
  .load_cmd_v_i      (load_cmd_v_i),
  .proc_cmd_i        (proc_cmd_i),
  .proc_cmd_v_i      (proc_cmd_v_i),
  .load_cmd_ready_o  (load_cmd_ready_o),
  .proc_cmd_ready_o  (proc_cmd_ready_o),
  .reg_cmd_v_o       (reg_cmd_v_o),
  .mem_cmd_v_o       (mem_cmd_v_o),
  .load_resp_o       (load_resp_o),
  .load_resp_v_o     (load_resp_v_o),
  .load_resp_ready_i (load_resp_ready_i),
  .proc_resp_o       (proc_resp_o),
  .proc_resp_v_o     (proc_resp_v_o),
  .proc_resp_ready_i (proc_resp_ready_i)
);

`default_nettype wire

// ==== src/host_top.sv ====
// I/O host block serving loader and processor command ports.
// One command in flight; register responses after 2 cycles,
// memory responses after 3, stretched by response back-pressure.
// Trace enables are plain register outputs.
`timescale 1ns/100ps
`default_nettype none

module host_top
(
  input  wire                                  clk_i,
  input  wire                                  arst_n_i,

  input  host_pkg::io_cmd_t                    load_cmd_i,
  input  wire                                  load_cmd_v_i,
  output logic                                 load_cmd_ready_o,
  output host_pkg::io_resp_t                   load_resp_o,
  output logic                                 load_resp_v_o,
  input  wire                                  load_resp_ready_i,

  input  host_pkg::io_cmd_t                    proc_cmd_i,
  input  wire                                  proc_cmd_v_i,
  output logic                                 proc_cmd_ready_o,
  output host_pkg::io_resp_t                   proc_resp_o,
  output logic                                 proc_resp_v_o,
  input  wire                                  proc_resp_ready_i,

  output logic [host_pkg::TRACE_W-1:0]         trace_en_o,
  output logic [host_pkg::NUM_CORES-1:0]       finish_o,
  output logic                                 all_finished_o
);

  host_pkg::io_cmd_t   tgt_cmd;
  logic                reg_cmd_v;
  logic                mem_cmd_v;
  host_pkg::io_resp_t  reg_resp;
  logic                reg_resp_v;
  host_pkg::io_resp_t  mem_resp;
  logic                mem_resp_v;

  io_port_arbiter u_arbiter
  (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .load_cmd_i        (load_cmd_i),
    .load_cmd_v_i      (load_cmd_v_i),
    .load_cmd_ready_o  (load_cmd_ready_o),
    .load_resp_o       (load_resp_o),
    .load_resp_v_o     (load_resp_v_o),
    .load_resp_ready_i (load_resp_ready_i),
    .proc_cmd_i        (proc_cmd_i),
    .proc_cmd_v_i      (proc_cmd_v_i),
    .proc_cmd_ready_o  (proc_cmd_ready_o),
    .proc_resp_o       (proc_resp_o),
    .proc_resp_v_o     (proc_resp_v_o),
    .proc_resp_ready_i (proc_resp_ready_i),
    .tgt_cmd_o         (tgt_cmd),
    .reg_cmd_v_o       (reg_cmd_v),
    .mem_cmd_v_o       (mem_cmd_v),
    .reg_resp_i        (reg_resp),
    .reg_resp_v_i      (reg_resp_v),
    .mem_resp_i        (mem_resp),
    .mem_resp_v_i      (mem_resp_v)
  );

  host_regs u_regs
  (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .cmd_i          (tgt_cmd),
    .cmd_v_i        (reg_cmd_v),
    .resp_o         (reg_resp),
    .resp_v_o       (reg_resp_v),
    .trace_en_o     (trace_en_o),
    .finish_o       (finish_o),
    .all_finished_o (all_finished_o)
  );

  mem_model u_mem
  (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .cmd_i    (tgt_cmd),
    .cmd_v_i  (mem_cmd_v),
    .resp_o   (mem_resp),
    .resp_v_o (mem_resp_v)
  );

endmodule

`default_nettype wire

// ==== src/mem_model.sv ====
// Word-addressed stand-in for DRAM, 256 words of 32 bits.
// Only the low 8 address bits index the array.
// Fixed two-cycle response; contents are undefined until written.
`timescale 1ns/100ps
`default_nettype none

module mem_model
(
  input  wire                 clk_i,
  input  wire                 arst_n_i,
  input  host_pkg::io_cmd_t   cmd_i,
  input  wire                 cmd_v_i,
  output host_pkg::io_resp_t  resp_o,
  output logic                resp_v_o
);

  logic [host_pkg::DATA_W-1:0]     mem_q [host_pkg::MEM_WORDS];
  logic [host_pkg::MEM_IDX_W-1:0]  word_idx;
  logic                            is_write;

  logic                            s1_v_q;
  host_pkg::io_resp_t              s1_resp_q;
  logic                            s2_v_q;
  host_pkg::io_resp_t              s2_resp_q;

  assign word_idx = cmd_i.addr.mem.word;
  assign is_write = (cmd_i.op == host_pkg::IO_WRITE);

  always_ff @(posedge clk_i)
  begin
    if (cmd_v_i && is_write)
      mem_q[word_idx] <= cmd_i.data;
    // First stage captures read data, second stage presents it
    if (cmd_v_i)
    begin
      s1_resp_q.op   <= cmd_i.op;
      s1_resp_q.data <= is_write ? '0 : mem_q[word_idx];
    end
    if (s1_v_q)
      s2_resp_q <= s1_resp_q;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      s1_v_q <= 1'b0;
      s2_v_q <= 1'b0;
    end
    else
    begin
      s1_v_q <= cmd_v_i;
      s2_v_q <= s1_v_q;
    end
  end

  assign resp_o   = s2_resp_q;
  assign resp_v_o = s2_v_q;

endmodule

`default_nettype wire

// ==== src/host_regs.sv ====
// Host register region: trace enables and per-core finish flags.
// Response strobe follows cmd_v_i by one cycle.
// Finish flags are sticky and clear only on reset.
// Unknown selects read zero and drop writes.
`timescale 1ns/100ps
`default_nettype none

module host_regs
(
  input  wire                                  clk_i,
  input  wire                                  arst_n_i,
  input  host_pkg::io_cmd_t                    cmd_i,
  input  wire                                  cmd_v_i,
  output host_pkg::io_resp_t                   resp_o,
  output logic                                 resp_v_o,
  output logic [host_pkg::TRACE_W-1:0]         trace_en_o,
  output logic [host_pkg::NUM_CORES-1:0]       finish_o,
  output logic                                 all_finished_o
);

  logic [host_pkg::SEL_W-1:0]      reg_sel;
  logic [host_pkg::CORE_ID_W-1:0]  core_id;
  logic                            is_write;
  logic [host_pkg::DATA_W-1:0]     rd_data;

  logic [host_pkg::TRACE_W-1:0]    trace_q;
  logic [host_pkg::NUM_CORES-1:0]  finish_q;
  host_pkg::io_resp_t              resp_q;
  logic                            resp_v_q;

  assign reg_sel  = cmd_i.addr.host.reg_sel;
  assign core_id  = cmd_i.addr.host.core_id;
  assign is_write = (cmd_i.op == host_pkg::IO_WRITE);

  // Read-back mux, zero-extended
  always_comb
  begin
    rd_data = '0;
    case (reg_sel)
      host_pkg::REG_TRACE:  rd_data[host_pkg::TRACE_W-1:0]   = trace_q;
      host_pkg::REG_FINISH: rd_data[host_pkg::NUM_CORES-1:0] = finish_q;
      default:              rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      trace_q  <= '0;
      finish_q <= '0;
      resp_v_q <= 1'b0;
    end
    else
    begin
      resp_v_q <= cmd_v_i;
      if (cmd_v_i && is_write)
      begin
        case (reg_sel)
          host_pkg::REG_TRACE:  trace_q <= cmd_i.data[host_pkg::TRACE_W-1:0];
          host_pkg::REG_FINISH: finish_q[core_id] <= 1'b1;
          default:              ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_v_i)
    begin
      resp_q.op   <= cmd_i.op;
      resp_q.data <= is_write ? '0 : rd_data;
    end
  end

  assign resp_o         = resp_q;
  assign resp_v_o       = resp_v_q;
  assign trace_en_o     = trace_q;
  assign finish_o       = finish_q;
  assign all_finished_o = &finish_q;

endmodule

`default_nettype wire

// ==== src/io_port_arbiter.sv ====
// Two-port command arbiter with a single command in flight.
// Loader wins when both ports are valid; the processor ready is held
// low in that cycle so its command waits.
// Target strobes come one cycle after the command transfer.
// The response is held until the issuing port takes it.
`timescale 1ns/100ps
`default_nettype none

module io_port_arbiter
(
  input  wire                 clk_i,
  input  wire                 arst_n_i,

  input  host_pkg::io_cmd_t   load_cmd_i,
  input  wire                 load_cmd_v_i,
  output logic                load_cmd_ready_o,
  output host_pkg::io_resp_t  load_resp_o,
  output logic                load_resp_v_o,
  input  wire                 load_resp_ready_i,

  input  host_pkg::io_cmd_t   proc_cmd_i,
  input  wire                 proc_cmd_v_i,
  output logic                proc_cmd_ready_o,
  output host_pkg::io_resp_t  proc_resp_o,
  output logic                proc_resp_v_o,
  input  wire                 proc_resp_ready_i,

  output host_pkg::io_cmd_t   tgt_cmd_o,
  output logic                reg_cmd_v_o,
  output logic                mem_cmd_v_o,

  input  host_pkg::io_resp_t  reg_resp_i,
  input  wire                 reg_resp_v_i,
  input  host_pkg::io_resp_t  mem_resp_i,
  input  wire                 mem_resp_v_i
);

  host_pkg::io_cmd_t    sel_cmd;
  host_pkg::port_src_e  sel_src;
  logic                 accept;
  logic                 resp_fire;
  logic                 sel_host;

  logic                 busy_q;
  host_pkg::port_src_e  src_q;
  host_pkg::io_cmd_t    cmd_q;
  logic                 reg_v_q;
  logic                 mem_v_q;
  host_pkg::io_resp_t   resp_q;
  logic                 resp_v_q;

  // Fixed priority, loader first
  always_comb
  begin
    if (load_cmd_v_i)
    begin
      sel_cmd = load_cmd_i;
      sel_src = host_pkg::SRC_LOAD;
    end
    else
    begin
      sel_cmd = proc_cmd_i;
      sel_src = host_pkg::SRC_PROC;
    end
  end

  assign sel_host = sel_cmd.addr[host_pkg::HOST_REGION_BIT];

  assign load_cmd_ready_o = ~busy_q;
  assign proc_cmd_ready_o = ~busy_q & ~load_cmd_v_i;
  assign accept           = ~busy_q & (load_cmd_v_i | proc_cmd_v_i);

  assign load_resp_o   = resp_q;
  assign proc_resp_o   = resp_q;
  assign load_resp_v_o = resp_v_q & (src_q == host_pkg::SRC_LOAD);
  assign proc_resp_v_o = resp_v_q & (src_q == host_pkg::SRC_PROC);
  assign resp_fire     = (load_resp_v_o & load_resp_ready_i)
                       | (proc_resp_v_o & proc_resp_ready_i);

  assign tgt_cmd_o   = cmd_q;
  assign reg_cmd_v_o = reg_v_q;
  assign mem_cmd_v_o = mem_v_q;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      busy_q   <= 1'b0;
      src_q    <= host_pkg::SRC_LOAD;
      reg_v_q  <= 1'b0;
      mem_v_q  <= 1'b0;
      resp_v_q <= 1'b0;
    end
    else
    begin
      reg_v_q <= accept & sel_host;
      mem_v_q <= accept & ~sel_host;
      if (accept)
      begin
        busy_q <= 1'b1;
        src_q  <= sel_src;
      end
      else if (resp_fire)
      begin
        busy_q <= 1'b0;
      end
      // Targets answer once per command, never together
      if (reg_resp_v_i | mem_resp_v_i)
        resp_v_q <= 1'b1;
      else if (resp_fire)
        resp_v_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      cmd_q <= sel_cmd;
    if (reg_resp_v_i)
      resp_q <= reg_resp_i;
    else if (mem_resp_v_i)
      resp_q <= mem_resp_i;
  end

endmodule

`default_nettype wire

// ==== src/host_pkg.sv ====
// Shared types and address map for the I/O host block.
// Bit 15 of the command address picks host registers (1) or memory (0).
// Memory uses the low 8 address bits only, so bits 14..8 alias.
// Host registers take a 4-bit select in bits 5..2 and a core id in bits 1..0.
`default_nettype none

package host_pkg;

  localparam int ADDR_W          = 16;
  localparam int DATA_W          = 32;
  localparam int NUM_CORES       = 4;
  localparam int TRACE_W         = 8;
  localparam int MEM_WORDS       = 256;
  localparam int MEM_IDX_W       = 8;
  localparam int HOST_REGION_BIT = 15;
  localparam int SEL_W           = 4;
  localparam int CORE_ID_W       = 2;

  // Host register selects
  localparam logic [SEL_W-1:0] REG_TRACE  = 4'd0;
  localparam logic [SEL_W-1:0] REG_FINISH = 4'd1;

  typedef enum logic
  {
    IO_READ  = 1'b0,
    IO_WRITE = 1'b1
  } io_op_e;

  typedef enum logic
  {
    SRC_LOAD = 1'b0,
    SRC_PROC = 1'b1
  } port_src_e;

  // Memory view of a command address
  typedef struct packed
  {
    logic                           region;
    logic [ADDR_W-2-MEM_IDX_W:0]    unused;
    logic [MEM_IDX_W-1:0]           word;
  } io_addr_mem_t;

  // Host register view of a command address
  typedef struct packed
  {
    logic                                region;
    logic [ADDR_W-2-SEL_W-CORE_ID_W:0]   unused;
    logic [SEL_W-1:0]                    reg_sel;
    logic [CORE_ID_W-1:0]                core_id;
  } io_addr_host_t;

  typedef union packed
  {
    io_addr_mem_t  mem;
    io_addr_host_t host;
  } io_addr_u;

  typedef struct packed
  {
    io_op_e              op;
    io_addr_u            addr;
    logic [DATA_W-1:0]   data;
  } io_cmd_t;

  // Writes answer with data zero
  typedef struct packed
  {
    io_op_e              op;
    logic [DATA_W-1:0]   data;
  } io_resp_t;

endpackage

`default_nettype wire
